//--- larpix_trace.txt
# op then hex fields: W addr data | R addr expect | H chans dout | E chip chans adc
# S sync | O reads held, wait for half full | D drain and match the expected set
# reset defaults, then writes and an unmapped address
R 00 01
R 01 ff
R 02 00
R 03 02
R 04 02
R 1f 00
W 00 05
R 00 05
W 04 03
R 04 03
W 10 aa
R 10 00
# single hit on channel 0
H 01 155
E 05 01 155
D
# channel 2 masked, channel 3 csa off
W 02 04
W 01 f7
H 0c 0aa
D
W 02 00
W 01 ff
# four channels at once
H f0 2a3
E 05 f0 2a3
D
# hits after sync on channel 1 with a longer hold
S
W 03 04
H 02 011
H 02 022
E 05 02 011
E 05 02 022
D
# reads held while the shared fifo fills
H ff 100
H ff 200
H ff 300
O
E 05 ff 100
E 05 ff 200
E 05 ff 300
D

//--- larpix_core.f
larpix_cfg_pkg.sv
larpix_pkt_pkg.sv
fifo_wr_if.sv
config_regmap.sv
channel_ctrl.sv
event_router.sv
shared_fifo.sv
larpix_core.sv
tb_larpix_core.sv

//--- Bender.yml
package:
  name: larpix_core

sources:
  - larpix_cfg_pkg.sv
  - larpix_pkt_pkg.sv
  - fifo_wr_if.sv
  - config_regmap.sv
  - channel_ctrl.sv
  - event_router.sv
  - shared_fifo.sv
  - larpix_core.sv
  - target: test
    files:
      - tb_larpix_core.sv

//--- tb_larpix_core.sv
module tb_larpix_core;
    import larpix_cfg_pkg::*;
    import larpix_pkt_pkg::*;

    localparam int NUM_CH = 8;
    localparam int LDEPTH = 4;
    localparam int FDEPTH = 16;
    localparam int TMO    = 600;  // cycles allowed per wait

    logic                       clk;
    logic                       arst_n;
    logic [NUM_CH-1:0]          hit;
    logic [NUM_CH-1:0]          done;
    logic [NUM_CH*ADC_BITS-1:0] dout;
    logic                       sync;
    logic [REG_ADDR_W-1:0]      cfg_addr;
    logic [REG_DATA_W-1:0]      cfg_wdata;
    logic                       cfg_we;
    logic [REG_DATA_W-1:0]      cfg_rdata;
    logic [NUM_CH-1:0]          sample;
    logic [NUM_CH-1:0]          csa_reset;
    logic                       event_rd;
    packet_t                    event_pkt;
    logic                       event_valid;
    logic                       fifo_half;

    logic [NUM_CH-1:0] csa_en_m;         // tb copy of csa_enable
    logic [NUM_CH-1:0] mask_m;           // tb copy of channel_mask
    int unsigned       since_sync;       // edges since last sync
    longint            last_ts [NUM_CH]; // -1 until a channel reports
    logic [23:0]       exp_q [$];        // {chip, chan, adc} still expected
    int                bnd_chan [$];     // channel of each accepted hit
    longint            bnd_ts [$];       // timestamp limit of that hit

    larpix_core #(
        .NUM_CHANNELS (NUM_CH),
        .LOCAL_DEPTH  (LDEPTH),
        .FIFO_DEPTH   (FDEPTH)
    ) u_larpix_core (
        .clk           (clk),
        .arst_n_i      (arst_n),
        .hit_i         (hit),
        .done_i        (done),
        .dout_i        (dout),
        .sync_i        (sync),
        .cfg_addr_i    (cfg_addr),
        .cfg_wdata_i   (cfg_wdata),
        .cfg_we_i      (cfg_we),
        .cfg_rdata_o   (cfg_rdata),
        .sample_o      (sample),
        .csa_reset_o   (csa_reset),
        .event_rd_i    (event_rd),
        .event_o       (event_pkt),
        .event_valid_o (event_valid),
        .fifo_half_o   (fifo_half)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            since_sync <= 0;
        end else if (sync) begin
            since_sync <= 0;  // count restarts with sync
        end else begin
            since_sync <= since_sync + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checking and host access
    ////////////////////////////////////////////////////////////////////////////
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR t=%0t %s got 0x%0h expected 0x%0h",
                                $time, name, got, exp));
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
        @(posedge clk);
        cfg_addr  <= addr;
        cfg_wdata <= data;
        cfg_we    <= 1'b1;
        @(posedge clk);
        cfg_we    <= 1'b0;
        if (addr == REG_CSA_ENABLE) begin
            csa_en_m = data;
        end
        if (addr == REG_CHANNEL_MASK) begin
            mask_m = data;
        end
    endtask

    task automatic read_reg(input logic [7:0] addr, input logic [7:0] exp);
        @(posedge clk);
        cfg_addr <= addr;
        @(posedge clk);  // read data registered here
        @(negedge clk);
        compare($sformatf("cfg_rdata_o[0x%0h]", addr), cfg_rdata, exp);
    endtask

    task automatic sync_pulse();
        @(posedge clk);
        sync <= 1'b1;
        @(posedge clk);
        sync <= 1'b0;
        foreach (last_ts[i]) begin
            last_ts[i] = -1;  // timestamps restart
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // hit, hold, convert, reset on a set of channels
    ////////////////////////////////////////////////////////////////////////////
    task automatic run_hit(input logic [NUM_CH-1:0] chans, input logic [ADC_BITS-1:0] adc);
        logic [NUM_CH-1:0] acc;
        logic [NUM_CH-1:0] off_m;
        logic [NUM_CH-1:0] seen;
        int unsigned       dly [NUM_CH];
        int                n;
        acc   = chans & csa_en_m & ~mask_m;  // channels that take the hit
        off_m = ~csa_en_m;
        @(posedge clk);
        hit  <= chans;
        dout <= {NUM_CH{adc}};
        for (int g = 0; g < NUM_CH; g++) begin
            if (acc[g]) begin
                bnd_chan.push_back(g);
                bnd_ts.push_back(longint'(since_sync) + 3);  // k = count + 2, limit k + 1
            end
        end
        @(posedge clk);
        hit <= '0;
        n = 0;
        do begin
            @(negedge clk);
            compare("sample_o of rejected channels", sample & ~acc, '0);
            compare("csa_reset_o of disabled csa", csa_reset & off_m, off_m);
            n++;
            if (n > TMO) begin
                abort_run("timeout waiting for sample_o to rise on hit channels");
            end
        end while ((acc == '0) ? (n < 10) : ((sample & acc) != acc));
        n = 0;
        while ((sample & acc) != '0) begin
            compare("csa_reset_o during hold", csa_reset & acc, '0);
            @(negedge clk);
            n++;
            if (n > TMO) begin
                abort_run("timeout waiting for sample_o to fall");
            end
        end
        foreach (dly[g]) begin
            dly[g] = $urandom % 8;  // conversion time per channel
        end
        seen = '0;
        n    = 0;
        while (acc != '0 && (seen != acc || (csa_reset & acc) != '0)) begin
            @(posedge clk);
            for (int g = 0; g < NUM_CH; g++) begin
                done[g] <= acc[g] && (dly[g] == n);
            end
            @(negedge clk);
            seen = seen | (csa_reset & acc);
            n++;
            if (n > TMO) begin
                abort_run("timeout waiting for csa_reset_o pulse after conversion");
            end
        end
        @(posedge clk);
        done <= '0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // shared fifo side
    ////////////////////////////////////////////////////////////////////////////
    task automatic add_expected(input logic [7:0] chip, input logic [NUM_CH-1:0] chans,
                                input logic [ADC_BITS-1:0] adc);
        for (int g = 0; g < NUM_CH; g++) begin
            if (chans[g]) begin
                exp_q.push_back({chip, CHAN_ID_W'(g), adc});
            end
        end
    endtask

    task automatic wait_fifo_fill();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TMO) begin
                abort_run("timeout waiting for fifo_half_o with reads held off");
            end
        end while (!fifo_half);
        compare("event_valid_o", event_valid, 1'b1);
    endtask

    task automatic check_event(input packet_t pkt);
        int idx;
        int ch;
        ch  = pkt.channel_id;
        idx = -1;
        compare("event_o parity", ^pkt, 1'b1);  // whole word odd
        compare("event_o reserved", pkt.reserved, '0);
        foreach (exp_q[i]) begin
            if (idx < 0 && exp_q[i] == {pkt.chip_id, pkt.channel_id, pkt.adc}) begin
                idx = i;
            end
        end
        compare("event_o in expected set", idx >= 0, 1'b1);
        exp_q.delete(idx);
        idx = -1;
        foreach (bnd_chan[i]) begin
            if (idx < 0 && bnd_chan[i] == ch) begin
                idx = i;  // oldest hit of this channel
            end
        end
        compare("event_o timestamp limit", pkt.timestamp <= bnd_ts[idx], 1'b1);
        if (last_ts[ch] >= 0) begin
            compare("event_o timestamp order", pkt.timestamp > last_ts[ch], 1'b1);
        end
        last_ts[ch] = pkt.timestamp;
        bnd_chan.delete(idx);
        bnd_ts.delete(idx);
    endtask

    task automatic drain_events();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            n++;
            if (n > TMO) begin
                abort_run("timeout waiting for expected events on event_o");
            end
            if (event_valid) begin
                check_event(event_pkt);
                @(posedge clk);
                event_rd <= 1'b1;  // pop seen head
                @(posedge clk);
                event_rd <= 1'b0;
            end
        end
        repeat (16) begin
            @(negedge clk);
            compare("event_valid_o after drain", event_valid, 1'b0);  // no extra event
            compare("fifo_half_o after drain", fifo_half, 1'b0);
        end
    endtask

    initial begin
        int          fd;
        string       line;
        byte         op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        void'($urandom(72390));
        arst_n    <= 1'b0;
        hit       <= '0;
        done      <= '0;
        dout      <= '0;
        sync      <= 1'b0;
        cfg_addr  <= '0;
        cfg_wdata <= '0;
        cfg_we    <= 1'b0;
        event_rd  <= 1'b0;
        csa_en_m = DEFAULT_CSA_ENABLE;
        mask_m   = DEFAULT_CHANNEL_MASK;
        foreach (last_ts[i]) begin
            last_ts[i] = -1;
        end
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        fd = $fopen("larpix_trace.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open larpix_trace.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                op = line.getc(0);
                a  = '0;
                b  = '0;
                c  = '0;
                void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c));
                case (op)
                    "W":     write_reg(a[7:0], b[7:0]);
                    "R":     read_reg(a[7:0], b[7:0]);
                    "H":     run_hit(a[NUM_CH-1:0], b[ADC_BITS-1:0]);
                    "S":     sync_pulse();
                    "O":     wait_fifo_fill();
                    "E":     add_expected(a[7:0], b[NUM_CH-1:0], c[ADC_BITS-1:0]);
                    "D":     drain_events();
                    default: abort_run($sformatf("unknown trace command: %s", line));
                endcase
            end
        end
        $fclose(fd);
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- larpix_core.sv
module larpix_core #(
    parameter int NUM_CHANNELS = 8,   // at most 8, one cfg bit each
    parameter int LOCAL_DEPTH  = 4,   // per-channel event fifo
    parameter int FIFO_DEPTH   = 16   // shared event fifo
) (
    input  logic                                             clk,
    input  logic                                             arst_n_i,
    input  logic [NUM_CHANNELS-1:0]                          hit_i,
    input  logic [NUM_CHANNELS-1:0]                          done_i,
    input  logic [NUM_CHANNELS*larpix_pkt_pkg::ADC_BITS-1:0] dout_i,
    input  logic                                             sync_i,
    input  logic [larpix_cfg_pkg::REG_ADDR_W-1:0]            cfg_addr_i,
    input  logic [larpix_cfg_pkg::REG_DATA_W-1:0]            cfg_wdata_i,
    input  logic                                             cfg_we_i,
    output logic [larpix_cfg_pkg::REG_DATA_W-1:0]            cfg_rdata_o,
    output logic [NUM_CHANNELS-1:0]                          sample_o,
    output logic [NUM_CHANNELS-1:0]                          csa_reset_o,
    input  logic                                             event_rd_i,
    output larpix_pkt_pkg::packet_t                          event_o,
    output logic                                             event_valid_o,
    output logic                                             fifo_half_o
);
    import larpix_cfg_pkg::*;
    import larpix_pkt_pkg::*;

    cfg_t                    cfg;          // decoded configuration
    logic [TS_W-1:0]         timestamp_q;  // free-running
    logic [NUM_CHANNELS-1:0] local_empty;
    logic [NUM_CHANNELS-1:0] local_rd;
    packet_t                 local_data [NUM_CHANNELS];

    fifo_wr_if u_fifo_wr_if ();  // router to shared fifo

    // sync zeroes the count for the next cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            timestamp_q <= '0;
        end else if (sync_i) begin
            timestamp_q <= '0;
        end else begin
            timestamp_q <= timestamp_q + 1'b1;
        end
    end

    config_regmap u_config_regmap (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .addr_i   (cfg_addr_i),
        .wdata_i  (cfg_wdata_i),
        .we_i     (cfg_we_i),
        .rdata_o  (cfg_rdata_o),
        .cfg_o    (cfg)
    );

    ////////////////////////////////////////////////////////////////////////////
    // channels, each with its own adc slice and config bits
    ////////////////////////////////////////////////////////////////////////////
    for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_chan
        channel_ctrl #(
            .LOCAL_DEPTH (LOCAL_DEPTH)
        ) u_channel_ctrl (
            .clk              (clk),
            .arst_n_i         (arst_n_i),
            .channel_id_i     (CHAN_ID_W'(g)),
            .chip_id_i        (cfg.chip_id),
            .csa_enable_i     (cfg.csa_enable[g]),
            .channel_mask_i   (cfg.channel_mask[g]),
            .adc_hold_delay_i (cfg.adc_hold_delay),
            .reset_length_i   (cfg.reset_length),
            .timestamp_i      (timestamp_q),
            .hit_i            (hit_i[g]),
            .done_i           (done_i[g]),
            .dout_i           (dout_i[g*ADC_BITS +: ADC_BITS]),
            .local_rd_i       (local_rd[g]),
            .sample_o         (sample_o[g]),
            .csa_reset_o      (csa_reset_o[g]),
            .local_empty_o    (local_empty[g]),
            .local_data_o     (local_data[g])
        );
    end

    event_router #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) u_event_router (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .local_empty_i (local_empty),
        .local_rd_o    (local_rd),
        .local_data_i  (local_data),
        .fifo          (u_fifo_wr_if.router)
    );

    shared_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_shared_fifo (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wr       (u_fifo_wr_if.fifo),
        .rd_i     (event_rd_i),
        .data_o   (event_o),
        .valid_o  (event_valid_o)
    );

    assign fifo_half_o = u_fifo_wr_if.half;

endmodule

//--- shared_fifo.sv
module shared_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                    clk,
    input  logic                    arst_n_i,
    fifo_wr_if.fifo                 wr,
    input  logic                    rd_i,
    output larpix_pkt_pkg::packet_t data_o,
    output logic                    valid_o
);
    import larpix_pkt_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    packet_t          mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;  // words held
    logic             do_rd;    // pop, ignored when empty

    assign valid_o = (count_q != '0);
    assign data_o  = mem[rd_ptr_q];  // fall-through head
    assign do_rd   = rd_i && valid_o;
    assign wr.full = (count_q == CNT_W'(FIFO_DEPTH));
    assign wr.half = (count_q >= CNT_W'(FIFO_DEPTH / 2));

    always_ff @(posedge clk) begin
        if (wr.wr) begin
            mem[wr_ptr_q] <= wr.data;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr.wr) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_rd) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({wr.wr, do_rd})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // host pops only a valid head
    a_no_empty_read: assert property (@(posedge clk) disable iff (!arst_n_i)
        rd_i |-> valid_o);

    // router must hold off while full
    a_no_full_write: assert property (@(posedge clk) disable iff (!arst_n_i)
        wr.wr |-> !wr.full);

endmodule

//--- event_router.sv
module event_router #(
    parameter int NUM_CHANNELS = 8
) (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic [NUM_CHANNELS-1:0] local_empty_i,
    output logic [NUM_CHANNELS-1:0] local_rd_o,
    input  larpix_pkt_pkg::packet_t local_data_i [NUM_CHANNELS],
    fifo_wr_if.router               fifo
);
    localparam int IDX_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;

    logic [IDX_W-1:0] last_q;  // last winner
    logic [IDX_W-1:0] sel;     // next non-empty channel after last_q
    logic             found;   // any channel has an event

    // round-robin search starting one past the last winner
    always_comb begin
        int unsigned idx;
        sel   = last_q;
        found = 1'b0;
        for (int k = 1; k <= NUM_CHANNELS; k++) begin
            idx = (int'(last_q) + k) % NUM_CHANNELS;
            if (!found && !local_empty_i[idx]) begin
                found = 1'b1;
                sel   = IDX_W'(idx);
            end
        end
    end

    // pop and write at the same edge, paused while shared fifo full
    assign fifo.wr   = found && !fifo.full;
    assign fifo.data = local_data_i[sel];

    always_comb begin
        local_rd_o      = '0;
        local_rd_o[sel] = fifo.wr;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            last_q <= IDX_W'(NUM_CHANNELS - 1);  // channel 0 first
        end else if (fifo.wr) begin
            last_q <= sel;
        end
    end

    // one pop per cycle, never from an empty channel
    a_single_pop: assert property (@(posedge clk) disable iff (!arst_n_i)
        $onehot0(local_rd_o) && ((local_rd_o & local_empty_i) == '0));

endmodule

//--- channel_ctrl.sv
module channel_ctrl #(
    parameter int LOCAL_DEPTH = 4  // local event fifo words
) (
    input  logic                                  clk,
    input  logic                                  arst_n_i,
    input  logic [larpix_pkt_pkg::CHAN_ID_W-1:0]  channel_id_i,
    input  logic [larpix_cfg_pkg::REG_DATA_W-1:0] chip_id_i,
    input  logic                                  csa_enable_i,
    input  logic                                  channel_mask_i,
    input  logic [larpix_cfg_pkg::REG_DATA_W-1:0] adc_hold_delay_i,
    input  logic [larpix_cfg_pkg::REG_DATA_W-1:0] reset_length_i,
    input  logic [larpix_pkt_pkg::TS_W-1:0]       timestamp_i,
    input  logic                                  hit_i,
    input  logic                                  done_i,
    input  logic [larpix_pkt_pkg::ADC_BITS-1:0]   dout_i,
    input  logic                                  local_rd_i,
    output logic                                  sample_o,
    output logic                                  csa_reset_o,
    output logic                                  local_empty_o,
    output larpix_pkt_pkg::packet_t               local_data_o
);
    import larpix_cfg_pkg::*;
    import larpix_pkt_pkg::*;

    localparam int PTR_W = $clog2(LOCAL_DEPTH);
    localparam int CNT_W = $clog2(LOCAL_DEPTH + 1);

    chan_state_e           state_q;
    logic [REG_DATA_W-1:0] cnt_q;     // hold / reset countdown
    logic [REG_DATA_W-1:0] hold_len;  // at least one cycle
    logic [REG_DATA_W-1:0] rst_len;   // at least one cycle
    logic [TS_W-1:0]       ts_q;      // hit time
    logic [ADC_BITS-1:0]   adc_q;     // converted sample
    logic                  accept;
    logic                  local_wr;
    logic                  local_full;
    packet_t               pkt;
    packet_t               mem [LOCAL_DEPTH];
    logic [PTR_W-1:0]      wr_ptr_q;
    logic [PTR_W-1:0]      rd_ptr_q;
    logic [CNT_W-1:0]      count_q;

    assign hold_len = (adc_hold_delay_i == '0) ? REG_DATA_W'(1) : adc_hold_delay_i;
    assign rst_len  = (reset_length_i == '0) ? REG_DATA_W'(1) : reset_length_i;

    // idle channel takes a hit only if live, unmasked and with room
    assign accept = (state_q == IDLE) && hit_i && csa_enable_i && !channel_mask_i
                    && !local_full;

    ////////////////////////////////////////////////////////////////////////////
    // hit / hold / convert / store / reset sequencer
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        state_q <= HOLD;
                        cnt_q   <= hold_len - 1'b1;
                    end
                end
                HOLD: begin
                    if (cnt_q == '0) begin
                        state_q <= CONVERT;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                CONVERT: begin
                    if (done_i) begin
                        state_q <= STORE;  // adc word captured below
                    end
                end
                STORE: begin
                    state_q <= RESET;
                    cnt_q   <= rst_len - 1'b1;
                end
                RESET: begin
                    if (cnt_q == '0) begin
                        state_q <= IDLE;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ts_q <= timestamp_i;
        end
        if (state_q == CONVERT && done_i) begin
            adc_q <= dout_i;
        end
    end

    assign sample_o    = (state_q == HOLD);
    assign csa_reset_o = (state_q == RESET) || !csa_enable_i;  // disabled csa stays reset

    always_comb begin
        pkt            = '0;  // reserved bits zero
        pkt.chip_id    = chip_id_i;
        pkt.channel_id = channel_id_i;
        pkt.timestamp  = ts_q;
        pkt.adc        = adc_q;
        pkt.parity     = odd_parity(pkt[PKT_W-2:0]);
    end

    ////////////////////////////////////////////////////////////////////////////
    // local event fifo, head always visible to the router
    ////////////////////////////////////////////////////////////////////////////
    assign local_wr      = (state_q == STORE);
    assign local_full    = (count_q == CNT_W'(LOCAL_DEPTH));
    assign local_empty_o = (count_q == '0);
    assign local_data_o  = mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (local_wr) begin
            mem[wr_ptr_q] <= pkt;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (local_wr) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(LOCAL_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (local_rd_i) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(LOCAL_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({local_wr, local_rd_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // room is checked at acceptance, several cycles before STORE
    a_no_local_overflow: assert property (@(posedge clk) disable iff (!arst_n_i)
        local_wr |-> !local_full);

    // hold sampling never overlaps a csa reset
    a_sample_in_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        sample_o |-> !csa_reset_o);

endmodule

//--- config_regmap.sv
module config_regmap (
    input  logic                                  clk,
    input  logic                                  arst_n_i,
    input  logic [larpix_cfg_pkg::REG_ADDR_W-1:0] addr_i,
    input  logic [larpix_cfg_pkg::REG_DATA_W-1:0] wdata_i,
    input  logic                                  we_i,
    output logic [larpix_cfg_pkg::REG_DATA_W-1:0] rdata_o,
    output larpix_cfg_pkg::cfg_t                  cfg_o
);
    import larpix_cfg_pkg::*;

    cfg_t                  cfg_q;   // live configuration
    logic [REG_DATA_W-1:0] rd_mux;  // addressed register

    // write side, one register per strobe
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cfg_q <= CFG_DEFAULT;
        end else if (we_i) begin
            case (addr_i)
                REG_CHIP_ID:        cfg_q.chip_id        <= wdata_i;
                REG_CSA_ENABLE:     cfg_q.csa_enable     <= wdata_i;
                REG_CHANNEL_MASK:   cfg_q.channel_mask   <= wdata_i;
                REG_ADC_HOLD_DELAY: cfg_q.adc_hold_delay <= wdata_i;
                REG_RESET_LENGTH:   cfg_q.reset_length   <= wdata_i;
                default: ;  // unmapped, dropped
            endcase
        end
    end

    always_comb begin
        case (addr_i)
            REG_CHIP_ID:        rd_mux = cfg_q.chip_id;
            REG_CSA_ENABLE:     rd_mux = cfg_q.csa_enable;
            REG_CHANNEL_MASK:   rd_mux = cfg_q.channel_mask;
            REG_ADC_HOLD_DELAY: rd_mux = cfg_q.adc_hold_delay;
            REG_RESET_LENGTH:   rd_mux = cfg_q.reset_length;
            default:            rd_mux = '0;  // unmapped reads zero
        endcase
    end

    // read data one cycle after the address
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rdata_o <= '0;
        end else begin
            rdata_o <= rd_mux;
        end
    end

    assign cfg_o = cfg_q;

endmodule

//--- fifo_wr_if.sv
interface fifo_wr_if;
    import larpix_pkt_pkg::*;

    logic    wr;    // write strobe, one word per high cycle
    packet_t data;  // word to store
    logic    full;  // no room, wr must stay low
    logic    half;  // at least half full

    modport router (output wr, output data, input full, input half);
    modport fifo   (input wr, input data, output full, output half);

endinterface

//--- larpix_pkt_pkg.sv
package larpix_pkt_pkg;

    localparam int ADC_BITS  = 10;  // adc word
    localparam int CHAN_ID_W = 6;   // channel id field
    localparam int TS_W      = 32;  // timestamp field
    localparam int PKT_W     = 64;  // full packet

    // data packet, msb first
    typedef struct packed {
        logic                 parity;      // odd over the other 63 bits
        logic [6:0]           reserved;    // always zero
        logic [7:0]           chip_id;
        logic [CHAN_ID_W-1:0] channel_id;
        logic [TS_W-1:0]      timestamp;   // latched at hit acceptance
        logic [ADC_BITS-1:0]  adc;
    } packet_t;

    // parity bit that makes the whole word odd
    function automatic logic odd_parity(input logic [PKT_W-2:0] bits);
        return ~^bits;
    endfunction

    typedef enum logic [2:0] {
        IDLE,
        HOLD,     // sample high
        CONVERT,  // waiting on adc done
        STORE,    // one cycle write to local fifo
        RESET     // csa reset high
    } chan_state_e;

endpackage

//--- larpix_cfg_pkg.sv
package larpix_cfg_pkg;

    localparam int REG_ADDR_W = 8;  // host address bits
    localparam int REG_DATA_W = 8;  // host data bits

    // register map, any other address reads zero
    typedef enum logic [REG_ADDR_W-1:0] {
        REG_CHIP_ID        = 8'h00,
        REG_CSA_ENABLE     = 8'h01,
        REG_CHANNEL_MASK   = 8'h02,
        REG_ADC_HOLD_DELAY = 8'h03,
        REG_RESET_LENGTH   = 8'h04
    } reg_addr_e;

    localparam logic [REG_DATA_W-1:0] DEFAULT_CHIP_ID        = 8'd1;
    localparam logic [REG_DATA_W-1:0] DEFAULT_CSA_ENABLE     = 8'hff;  // all csas live
    localparam logic [REG_DATA_W-1:0] DEFAULT_CHANNEL_MASK   = 8'h00;  // nothing masked
    localparam logic [REG_DATA_W-1:0] DEFAULT_ADC_HOLD_DELAY = 8'd2;
    localparam logic [REG_DATA_W-1:0] DEFAULT_RESET_LENGTH   = 8'd2;

    typedef struct packed {
        logic [REG_DATA_W-1:0] chip_id;         // stamped into every packet
        logic [REG_DATA_W-1:0] csa_enable;      // low keeps csa in reset
        logic [REG_DATA_W-1:0] channel_mask;    // high disables channel
        logic [REG_DATA_W-1:0] adc_hold_delay;  // sample cycles
        logic [REG_DATA_W-1:0] reset_length;    // csa reset cycles
    } cfg_t;

    localparam cfg_t CFG_DEFAULT = '{
        chip_id:        DEFAULT_CHIP_ID,
        csa_enable:     DEFAULT_CSA_ENABLE,
        channel_mask:   DEFAULT_CHANNEL_MASK,
        adc_hold_delay: DEFAULT_ADC_HOLD_DELAY,
        reset_length:   DEFAULT_RESET_LENGTH
    };

endpackage
